//--- compile.f
+incdir+tests
design/l1_cache_pkg.sv
design/sram_wrapper.sv
design/tag_array.sv
design/cache_ctrl.sv
design/cache_csr.sv
design/l1_cache_top.sv
tests/tb_l1_cache.sv

//--- run.sh
#!/bin/sh
# builds the L1 cache testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_l1_cache \
    -Mdir obj_dir -o sim_tb_l1_cache

./obj_dir/sim_tb_l1_cache | tee sim.log

if grep -q "^all tests passed$" sim.log; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail"
exit 1

//--- tests/tb_l1_cache_tasks.svh
// ****************************************
// directed tests plus CPU, register and compare helpers,
// included into the body of the cache testbench
// ****************************************

    task automatic compare_word(input string name, input word_t exp, input word_t got);
        if (got !== exp) begin
            $display("ERR %s: expected 0x%04h, got 0x%04h", name, exp, got);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic begin_test();
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %s: PASS", name);
        end else begin
            $display("test %s: FAIL with %0d errors", name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    function automatic word_t ctrl_value(input logic en, input logic flush);
        word_t v;
        v                 = '0;
        v[CTRL_EN_BIT]    = en;
        v[CTRL_FLUSH_BIT] = flush;
        return v;
    endfunction

    function automatic word_t line_addr(input logic [N_TAG_BITS-1:0] tag,
                                        input logic [N_SET_BITS-1:0] set, input logic off);
        return {tag, set, off};
    endfunction

    task automatic csr_write(input logic [1:0] a, input word_t d);
        csr_we    = 1'b1;
        csr_addr  = a;
        csr_wdata = d;
        @(posedge CLK);
        #1;
        csr_we = 1'b0;
    endtask

    task automatic csr_read(input logic [1:0] a, output word_t d);
        csr_addr = a;
        @(posedge CLK);    // combinational read, sampled mid cycle
        #1;
        d = csr_rdata;
    endtask

    task automatic csr_expect(input logic [1:0] a, input word_t exp, input string name);
        word_t d;
        csr_read(a, d);
        compare_word(name, exp, d);
    endtask

    // one access, reports cycles from req to ready and any mem_req seen
    task automatic cpu_access(input logic wr, input word_t a, input word_t d,
                              output word_t rd, output int cycles, output logic saw_mem);
        req     = 1'b1;
        we      = wr;
        addr    = a;       // held until the next access
        wdata   = d;
        @(posedge CLK);
        #1;
        req     = 1'b0;
        cycles  = 1;
        saw_mem = mem_req;
        while (!ready) begin
            @(posedge CLK);
            #1;
            cycles++;
            saw_mem = saw_mem | mem_req;    // ready cycle included
        end
        rd = rdata;
        @(posedge CLK);    // back to idle before the next req
        #1;
    endtask

    task automatic read_and_check(input word_t a, input logic from_cache);
        word_t rd;
        int    cycles;
        logic  saw_mem;
        int    reads_before;
        reads_before = mem_reads;
        cpu_access(1'b0, a, '0, rd, cycles, saw_mem);
        compare_word("rdata", ref_mem[a], rd);
        if (from_cache && cycles != 1) begin
            report_failure($sformatf("read hit at 0x%04h took %0d cycles instead of 1",
                                     a, cycles));
        end
        if (from_cache && (saw_mem || mem_reads != reads_before)) begin
            report_failure($sformatf("read hit at 0x%04h went out to memory", a));
        end
        if (!from_cache && !saw_mem) begin
            report_failure($sformatf("read at 0x%04h never raised mem_req", a));
        end
        if (!from_cache && mem_reads != reads_before + 1) begin
            report_failure($sformatf("read at 0x%04h fetched %0d blocks instead of 1",
                                     a, mem_reads - reads_before));
        end
    endtask

    task automatic write_and_check(input word_t a, input word_t d);
        word_t rd;
        int    cycles;
        logic  saw_mem;
        int    writes_before;
        writes_before = mem_writes;
        cpu_access(1'b1, a, d, rd, cycles, saw_mem);
        ref_mem[a] = d;    // write-through, memory always takes the word
        if (mem_writes != writes_before + 1) begin
            report_failure($sformatf("write at 0x%04h did not reach memory once", a));
        end
        compare_word("memory word", ref_mem[a], mem_model[a]);
    endtask

    task automatic check_reset_state();
        begin_test();
        compare_word("ready", '0, word_t'(ready));
        compare_word("mem_req", '0, word_t'(mem_req));
        csr_expect(CSR_CTRL, '0, "csr_rdata ctrl");
        csr_expect(CSR_HITS, '0, "csr_rdata hits");
        csr_expect(CSR_MISSES, '0, "csr_rdata misses");
        end_test("reset_state");
    endtask

    task automatic miss_then_hit();
        begin_test();
        csr_write(CSR_CTRL, ctrl_value(1'b1, 1'b0));
        read_and_check(16'h1234, 1'b0);    // fetches the block
        read_and_check(16'h1235, 1'b1);    // other word of that block
        csr_expect(CSR_HITS, 16'd1, "csr_rdata hits");
        csr_expect(CSR_MISSES, 16'd1, "csr_rdata misses");
        end_test("miss_then_hit");
    endtask

    task automatic write_through();
        word_t misses_before;
        word_t misses_after;
        begin_test();
        csr_write(CSR_HITS, '0);
        csr_write(CSR_MISSES, '0);
        write_and_check(16'h1234, 16'hbeef);    // hit, updates sram and memory
        read_and_check(16'h1234, 1'b1);
        csr_expect(CSR_HITS, 16'd2, "csr_rdata hits");
        write_and_check(16'h4a10, 16'h0c0d);    // miss, memory only
        csr_read(CSR_MISSES, misses_before);
        read_and_check(16'h4a10, 1'b0);         // not allocated by the write
        csr_read(CSR_MISSES, misses_after);
        compare_word("csr_rdata misses", misses_before + 16'd1, misses_after);
        end_test("write_through");
    endtask

    task automatic lru_replacement();
        word_t a_addr;
        word_t b_addr;
        word_t c_addr;
        begin_test();
        a_addr = line_addr(9'h011, 6'd5, 1'b0);   // same set, three tags
        b_addr = line_addr(9'h022, 6'd5, 1'b1);
        c_addr = line_addr(9'h033, 6'd5, 1'b1);
        read_and_check(a_addr, 1'b0);
        read_and_check(b_addr, 1'b0);
        read_and_check(a_addr, 1'b1);    // B now least recently used
        read_and_check(c_addr, 1'b0);    // evicts B
        read_and_check(a_addr, 1'b1);
        read_and_check(b_addr, 1'b0);
        end_test("lru_replacement");
    endtask

    task automatic flush_invalidates();
        begin_test();
        read_and_check(16'h1235, 1'b1);
        csr_write(CSR_CTRL, ctrl_value(1'b1, 1'b1));
        csr_expect(CSR_CTRL, ctrl_value(1'b1, 1'b0), "csr_rdata ctrl");   // flush reads 0
        read_and_check(16'h1235, 1'b0);
        read_and_check(16'h1234, 1'b1);    // refilled block holds the written word
        end_test("flush");
    endtask

    task automatic bypass_when_disabled();
        word_t hits_before;
        word_t misses_before;
        begin_test();
        csr_write(CSR_CTRL, ctrl_value(1'b0, 1'b0));
        csr_read(CSR_HITS, hits_before);
        csr_read(CSR_MISSES, misses_before);
        read_and_check(16'h1234, 1'b0);    // cached, still served by memory
        write_and_check(16'h1234, 16'h7e57);
        read_and_check(16'h1234, 1'b0);
        read_and_check(16'h0abc, 1'b0);
        csr_expect(CSR_HITS, hits_before, "csr_rdata hits");
        csr_expect(CSR_MISSES, misses_before, "csr_rdata misses");
        end_test("bypass");
    endtask

//--- tests/tb_l1_cache.sv
// ****************************************
// testbench for the two-way L1 data cache: clock, reset,
// memory model with random ack delay, watchdog, test sequence
// ****************************************
`timescale 1ns/100ps

module tb_l1_cache;
    import l1_cache_pkg::*;

    localparam int          N_ACCESS        = 19;     // cpu accesses over the whole run
    localparam int          WATCHDOG_CYCLES = N_ACCESS * 20 + 100;
    localparam logic [31:0] SEED            = 32'h9a02464b;

    logic       CLK = 1'b0;
    logic       rst_n;
    logic       req;
    logic       we;
    word_t      addr;
    word_t      wdata;
    word_t      rdata;
    logic       ready;
    logic       mem_req;
    logic       mem_we;
    word_t      mem_addr;
    block_t     mem_wdata;
    block_t     mem_rdata;
    logic       mem_ack;
    logic       csr_we;
    logic [1:0] csr_addr;
    word_t      csr_wdata;
    word_t      csr_rdata;

    word_t mem_model [65536];    // contents of the memory behind the cache
    word_t ref_mem   [65536];    // expected memory contents, predicts every read
    int    mem_reads;            // acked block reads
    int    mem_writes;           // acked word writes
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;

    always #5 CLK = ~CLK;        // 10 ns period

    l1_cache_top l1_cache_top_inst (
        .CLK, .rst_n,
        .req, .we, .addr, .wdata, .rdata, .ready,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack,
        .csr_we, .csr_addr, .csr_wdata, .csr_rdata
    );

    `include "tb_l1_cache_tasks.svh"

    // odd multiplier, every address bit changes the word
    function automatic word_t fill_pattern(input int unsigned a);
        word_t w;
        w = a[15:0];
        return (w * 16'h9e37) ^ 16'h3c5a;
    endfunction

    // memory side: ack 1 to 4 cycles after mem_req shows up
    initial begin : memory_model
        int delay;
        void'($urandom(SEED));
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge CLK);
            #1;
            if (mem_req) begin
                delay = $urandom_range(4, 1);
                repeat (delay - 1) begin
                    @(posedge CLK);
                    #1;
                end
                if (mem_we) begin    // only the slot picked by the cpu address
                    mem_model[{mem_addr[15:1], addr[0]}] = mem_wdata[addr[0]];
                    mem_writes++;
                end else begin
                    mem_rdata[0] = mem_model[{mem_addr[15:1], 1'b0}];
                    mem_rdata[1] = mem_model[{mem_addr[15:1], 1'b1}];
                    mem_reads++;
                end
                mem_ack = 1'b1;
                @(posedge CLK);
                #1;
                mem_ack = 1'b0;      // mem_req has dropped by now
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        rst_n           = 1'b0;
        req             = 1'b0;
        we              = 1'b0;
        addr            = '0;
        wdata           = '0;
        csr_we          = 1'b0;
        csr_addr        = '0;
        csr_wdata       = '0;
        mem_reads       = 0;
        mem_writes      = 0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        for (int i = 0; i < 65536; i++) begin
            mem_model[i[15:0]] = fill_pattern(i);
            ref_mem[i[15:0]]   = fill_pattern(i);
        end
        repeat (2) @(posedge CLK);    // two cycles in reset
        #1;
        rst_n = 1'b1;

        check_reset_state();
        miss_then_hit();
        write_through();
        lru_replacement();
        flush_invalidates();
        bypass_when_disabled();

        $display("summary: %0d tests run, %0d failing, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- design/l1_cache_top.sv
// ****************************************
// L1 data cache top: controller, tag array, data SRAM
// and register block wired to the CPU and memory ports
// ****************************************
`timescale 1ns/100ps

module l1_cache_top (
    input  logic                 CLK,
    input  logic                 rst_n,
    // cpu port
    input  logic                 req,
    input  logic                 we,
    input  l1_cache_pkg::word_t  addr,
    input  l1_cache_pkg::word_t  wdata,
    output l1_cache_pkg::word_t  rdata,
    output logic                 ready,
    // memory port
    output logic                 mem_req,
    output logic                 mem_we,
    output l1_cache_pkg::word_t  mem_addr,
    output l1_cache_pkg::block_t mem_wdata,
    input  l1_cache_pkg::block_t mem_rdata,
    input  logic                 mem_ack,
    // register port
    input  logic                 csr_we,
    input  logic [1:0]           csr_addr,
    input  l1_cache_pkg::word_t  csr_wdata,
    output l1_cache_pkg::word_t  csr_rdata
);
    import l1_cache_pkg::*;

    logic                    cache_en;
    logic                    flush_pulse;
    logic                    hit_pulse;
    logic                    miss_pulse;
    // tag array link
    cache_addr_u             lookup_addr;
    logic                    hit;
    logic [N_FRAME_BITS-1:0] hit_way;
    logic [N_FRAME_BITS-1:0] victim_way;
    logic                    fill;
    logic [N_FRAME_BITS-1:0] fill_way;
    logic                    touch;
    logic [N_FRAME_BITS-1:0] touch_way;
    logic                    clear;
    // sram link
    logic                    chip_select;
    logic                    write_enable;
    logic                    output_enable;
    logic [N_SET_BITS-1:0]   set_bits;
    logic [N_FRAME_BITS-1:0] frame_bits;
    block_t                  sram_wdata;
    block_t                  sram_rdata;

    cache_ctrl u_ctrl (
        .CLK, .rst_n,
        .req, .we, .addr, .wdata, .rdata, .ready,
        .cache_en, .flush_pulse, .hit_pulse, .miss_pulse,
        .hit, .hit_way, .victim_way, .lookup_addr,
        .fill, .fill_way, .touch, .touch_way, .clear,
        .sram_rdata, .chip_select, .write_enable, .output_enable,
        .set_bits, .frame_bits, .sram_wdata,
        .mem_rdata, .mem_ack, .mem_req, .mem_we, .mem_addr, .mem_wdata
    );

    tag_array u_tags (
        .CLK, .rst_n,
        .lookup_addr, .fill, .fill_way, .touch, .touch_way, .clear,
        .hit, .hit_way, .victim_way
    );

    sram_wrapper u_sram (
        .CLK, .rst_n,
        .set_bits, .frame_bits,
        .chip_select, .write_enable, .output_enable,
        .input_data  (sram_wdata),
        .output_data (sram_rdata)
    );

    cache_csr u_csr (
        .CLK, .rst_n,
        .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
        .hit_pulse, .miss_pulse, .cache_en, .flush_pulse
    );

endmodule

//--- design/cache_csr.sv
// ****************************************
// control register and hit/miss counters
// writes on the clock edge, reads are combinational
// ****************************************
`timescale 1ns/100ps

module cache_csr (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                csr_we,
    input  logic [1:0]          csr_addr,
    input  l1_cache_pkg::word_t csr_wdata,
    output l1_cache_pkg::word_t csr_rdata,
    input  logic                hit_pulse,
    input  logic                miss_pulse,
    output logic                cache_en,
    output logic                flush_pulse
);
    import l1_cache_pkg::*;

    word_t hits;
    word_t misses;
    logic  wr_ctrl;
    logic  wr_hits;
    logic  wr_misses;

    assign wr_ctrl   = csr_we && (csr_addr == CSR_CTRL);
    assign wr_hits   = csr_we && (csr_addr == CSR_HITS);
    assign wr_misses = csr_we && (csr_addr == CSR_MISSES);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cache_en    <= 1'b0;
            flush_pulse <= 1'b0;
            hits        <= '0;
            misses      <= '0;
        end else begin
            flush_pulse <= wr_ctrl && csr_wdata[CTRL_FLUSH_BIT];   // self clearing
            if (wr_ctrl) cache_en <= csr_wdata[CTRL_EN_BIT];

            // counters saturate at all ones, any write clears
            if (wr_hits) hits <= '0;
            else if (hit_pulse && (hits != '1)) hits <= hits + 1'b1;

            if (wr_misses) misses <= '0;
            else if (miss_pulse && (misses != '1)) misses <= misses + 1'b1;
        end
    end

    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            CSR_CTRL:   csr_rdata[CTRL_EN_BIT] = cache_en;   // flush bit reads 0
            CSR_HITS:   csr_rdata = hits;
            CSR_MISSES: csr_rdata = misses;
            default:    csr_rdata = '0;
        endcase
    end

endmodule

//--- design/cache_ctrl.sv
// ****************************************
// cache controller FSM: lookup, hit read, write-through,
// miss fill and bypass, drives SRAM strobes and tag updates
// ****************************************
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                                  CLK,
    input  logic                                  rst_n,
    // cpu side
    input  logic                                  req,
    input  logic                                  we,
    input  l1_cache_pkg::word_t                   addr,
    input  l1_cache_pkg::word_t                   wdata,
    output l1_cache_pkg::word_t                   rdata,
    output logic                                  ready,
    // control registers
    input  logic                                  cache_en,
    input  logic                                  flush_pulse,
    output logic                                  hit_pulse,
    output logic                                  miss_pulse,
    // tag array
    input  logic                                  hit,
    input  logic [l1_cache_pkg::N_FRAME_BITS-1:0] hit_way,
    input  logic [l1_cache_pkg::N_FRAME_BITS-1:0] victim_way,
    output l1_cache_pkg::cache_addr_u             lookup_addr,
    output logic                                  fill,
    output logic [l1_cache_pkg::N_FRAME_BITS-1:0] fill_way,
    output logic                                  touch,
    output logic [l1_cache_pkg::N_FRAME_BITS-1:0] touch_way,
    output logic                                  clear,
    // data sram
    input  l1_cache_pkg::block_t                  sram_rdata,
    output logic                                  chip_select,
    output logic                                  write_enable,
    output logic                                  output_enable,
    output logic [l1_cache_pkg::N_SET_BITS-1:0]   set_bits,
    output logic [l1_cache_pkg::N_FRAME_BITS-1:0] frame_bits,
    output l1_cache_pkg::block_t                  sram_wdata,
    // memory side
    input  l1_cache_pkg::block_t                  mem_rdata,
    input  logic                                  mem_ack,
    output logic                                  mem_req,
    output logic                                  mem_we,
    output l1_cache_pkg::word_t                   mem_addr,
    output l1_cache_pkg::block_t                  mem_wdata
);
    import l1_cache_pkg::*;

    logic [2:0]              state;
    logic [2:0]              state_nxt;
    cache_addr_u             req_addr;    // incoming address, decoded
    cache_addr_u             addr_q;      // address of the access in flight
    word_t                   wdata_q;
    word_t                   resp_q;      // word returned by memory
    logic                    we_q;
    logic [N_FRAME_BITS-1:0] way_q;       // hit way or fill victim
    logic                    merge_q;     // first cycle of a write hit
    logic                    idle;
    logic                    accept;
    block_t                  merged;

    assign req_addr.raw = addr;
    assign idle         = (state == ST_IDLE);
    assign accept       = idle && req;      // req while busy is dropped

    // lookup uses the live address only in the req cycle
    assign lookup_addr = idle ? req_addr : addr_q;
    assign set_bits    = lookup_addr.fields.set;
    assign fill_way    = way_q;
    assign touch_way   = hit_way;
    assign clear       = flush_pulse;

    // old block from the sram read on the req edge, new word patched in
    always_comb begin
        merged = sram_rdata;
        merged[addr_q.fields.offset] = wdata_q;
    end

    always_comb begin
        state_nxt     = state;
        chip_select   = 1'b0;
        write_enable  = 1'b0;
        output_enable = 1'b0;
        frame_bits    = way_q;
        sram_wdata    = merged;
        fill          = 1'b0;
        touch         = 1'b0;
        hit_pulse     = 1'b0;
        miss_pulse    = 1'b0;
        case (state)
            ST_IDLE: begin
                if (req && !cache_en) begin
                    state_nxt = ST_BYPASS;      // not counted
                end else if (req && hit) begin
                    hit_pulse     = 1'b1;
                    touch         = 1'b1;
                    chip_select   = 1'b1;       // read issued on the req edge
                    output_enable = 1'b1;
                    frame_bits    = hit_way;
                    state_nxt     = we ? ST_MEM_WRITE : ST_HIT_READ;
                end else if (req) begin
                    miss_pulse = 1'b1;
                    state_nxt  = we ? ST_BYPASS : ST_FILL_WAIT;   // no write allocate
                end
            end
            ST_MEM_WRITE: begin
                chip_select  = merge_q;         // sram write-back once, memory in parallel
                write_enable = merge_q;
                if (mem_ack) state_nxt = ST_DONE;
            end
            ST_FILL_WAIT: begin
                if (mem_ack) begin              // block goes straight into the victim way
                    chip_select  = 1'b1;
                    write_enable = 1'b1;
                    sram_wdata   = mem_rdata;
                    fill         = 1'b1;
                    state_nxt    = ST_REREAD;
                end
            end
            ST_REREAD: begin
                chip_select   = 1'b1;
                output_enable = 1'b1;
                state_nxt     = ST_HIT_READ;
            end
            ST_BYPASS: begin
                if (mem_ack) state_nxt = ST_DONE;
            end
            default: state_nxt = ST_IDLE;       // hit read and done last one cycle
        endcase
    end

    assign ready = (state == ST_HIT_READ) || (state == ST_DONE);
    assign rdata = (state == ST_DONE) ? resp_q : sram_rdata[addr_q.fields.offset];

    // memory port, level request held until ack
    assign mem_req   = (state == ST_MEM_WRITE) || (state == ST_FILL_WAIT) ||
                       (state == ST_BYPASS);
    assign mem_we    = (state == ST_MEM_WRITE) || ((state == ST_BYPASS) && we_q);
    assign mem_addr  = {addr_q.fields.tag, addr_q.fields.set, {N_OFF_BITS{1'b0}}};
    assign mem_wdata = {BLOCK_SIZE{wdata_q}};   // word in every slot, memory picks one

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            merge_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            merge_q <= accept && cache_en && hit && we;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            addr_q  <= req_addr;
            wdata_q <= wdata;
            we_q    <= we;
            way_q   <= hit ? hit_way : victim_way;
        end
        if ((state == ST_BYPASS) && mem_ack) resp_q <= mem_rdata[addr_q.fields.offset];
    end

endmodule

//--- design/tag_array.sv
// ****************************************
// tags, valid bits and LRU bit per set
// combinational lookup, fill/touch/clear on the clock edge
// ****************************************
`timescale 1ns/100ps

module tag_array (
    input  logic                                  CLK,
    input  logic                                  rst_n,
    input  l1_cache_pkg::cache_addr_u             lookup_addr,
    input  logic                                  fill,
    input  logic [l1_cache_pkg::N_FRAME_BITS-1:0] fill_way,
    input  logic                                  touch,
    input  logic [l1_cache_pkg::N_FRAME_BITS-1:0] touch_way,
    input  logic                                  clear,
    output logic                                  hit,
    output logic [l1_cache_pkg::N_FRAME_BITS-1:0] hit_way,
    output logic [l1_cache_pkg::N_FRAME_BITS-1:0] victim_way
);
    import l1_cache_pkg::*;

    logic [N_TAG_BITS-1:0]       tags [N_SET][ASSOC];
    logic [N_SET-1:0][ASSOC-1:0] valid;
    logic [N_SET-1:0]            lru;        // way to replace next
    logic [ASSOC-1:0]            way_hit;
    logic [N_SET_BITS-1:0]       set_idx;

    assign set_idx = lookup_addr.fields.set;

    // compare both ways at once
    always_comb begin
        for (int w = 0; w < ASSOC; w++) begin
            way_hit[w] = valid[set_idx][w] && (tags[set_idx][w] == lookup_addr.fields.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];    // two ways, so way 1 or else way 0

    // free way first, way 0 before way 1, then LRU
    always_comb begin
        if (!valid[set_idx][0]) victim_way = 1'b0;
        else if (!valid[set_idx][1]) victim_way = 1'b1;
        else victim_way = lru[set_idx];
    end

    always_ff @(posedge CLK) begin
        if (fill) tags[set_idx][fill_way] <= lookup_addr.fields.tag;
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            lru   <= '0;
        end else if (clear) begin       // flush, whole array in one cycle
            valid <= '0;
            lru   <= '0;
        end else if (fill) begin
            valid[set_idx][fill_way] <= 1'b1;
            lru[set_idx]             <= ~fill_way;   // other way is now older
        end else if (touch) begin
            lru[set_idx] <= ~touch_way;
        end
    end

endmodule

//--- design/sram_wrapper.sv
// ****************************************
// synchronous data SRAM, one block per set and way
// read data appears on the edge after output_enable
// ****************************************
`timescale 1ns/100ps

module sram_wrapper (
    input  logic                                  CLK,
    input  logic                                  rst_n,
    input  logic [l1_cache_pkg::N_SET_BITS-1:0]   set_bits,
    input  logic [l1_cache_pkg::N_FRAME_BITS-1:0] frame_bits,
    input  logic                                  chip_select,
    input  logic                                  write_enable,
    input  logic                                  output_enable,
    input  l1_cache_pkg::block_t                  input_data,
    output l1_cache_pkg::block_t                  output_data
);
    import l1_cache_pkg::*;

    block_t data_mem [N_SET][ASSOC];    // set x way array of blocks

    // write port, only when output_enable is low
    always_ff @(posedge CLK) begin
        if (chip_select && write_enable && !output_enable) begin
            data_mem[set_bits][frame_bits] <= input_data;
        end
    end

    // registered read port, holds its value between reads
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            output_data <= '0;
        end else if (chip_select && output_enable && !write_enable) begin
            output_data <= data_mem[set_bits][frame_bits];
        end
    end

endmodule

//--- design/l1_cache_pkg.sv
// ****************************************
// shared word, geometry and register definitions
// for the two-way L1 data cache, imported by every block
// ****************************************
package l1_cache_pkg;

    // word and address width
    localparam int WORD_W = 16;
    typedef logic [WORD_W-1:0] word_t;

    // cache geometry
    localparam int BLOCK_SIZE   = 2;     // words per block
    localparam int ASSOC        = 2;     // ways
    localparam int N_SET        = 64;
    localparam int N_SET_BITS   = 6;
    localparam int N_OFF_BITS   = 1;
    localparam int N_FRAME_BITS = 1;
    localparam int N_TAG_BITS   = WORD_W - N_SET_BITS - N_OFF_BITS;   // 9

    typedef word_t [BLOCK_SIZE-1:0] block_t;    // one cache block, word 0 in the low slot

    // word address seen either whole or split into tag/set/offset
    typedef union packed {
        word_t raw;
        struct packed {
            logic [N_TAG_BITS-1:0] tag;
            logic [N_SET_BITS-1:0] set;
            logic [N_OFF_BITS-1:0] offset;
        } fields;
    } cache_addr_u;

    // register map
    localparam logic [1:0] CSR_CTRL   = 2'd0;
    localparam logic [1:0] CSR_HITS   = 2'd1;
    localparam logic [1:0] CSR_MISSES = 2'd2;

    localparam int CTRL_EN_BIT    = 0;    // cache enable
    localparam int CTRL_FLUSH_BIT = 1;    // write 1 to invalidate, reads 0

    // controller states
    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_HIT_READ  = 3'd1;   // sram word on rdata, ready
    localparam logic [2:0] ST_MEM_WRITE = 3'd2;   // write-through of a hit
    localparam logic [2:0] ST_FILL_WAIT = 3'd3;   // block fetch, fill on ack
    localparam logic [2:0] ST_REREAD    = 3'd4;   // read the filled block back
    localparam logic [2:0] ST_BYPASS    = 3'd5;   // uncached or write-miss access
    localparam logic [2:0] ST_DONE      = 3'd6;   // ready for memory-side accesses

endpackage
